//--- common/hsi_mse_pkg.sv
package hsi_mse_pkg;

  // Sample width of one spectral band
  localparam int HM_DATA_WIDTH = 16;

  // Squared 17-bit difference
  localparam int HM_DATA_WIDTH_MUL = 34;

  // Room for many bands of full-scale squares
  localparam int HM_DATA_WIDTH_ACC = 48;

  // 1024 samples in the spectrum RAM
  localparam int HM_ADDR_WIDTH = 10;

  // Lane job controller states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // Waiting for job_req
    FETCH = 2'd1,  // Issuing sample reads
    DRAIN = 2'd2,  // Waiting for pipeline to empty
    DONE  = 2'd3   // Ack high until req drops
  } lane_state_e;

endpackage

//--- mse_lane/sq_df_acc.sv
`timescale 1ns/1ps

module sq_df_acc #(
  parameter int DATA_WIDTH     = hsi_mse_pkg::HM_DATA_WIDTH,      // Sample width
  parameter int DATA_WIDTH_MUL = hsi_mse_pkg::HM_DATA_WIDTH_MUL,  // Square width
  parameter int DATA_WIDTH_ACC = hsi_mse_pkg::HM_DATA_WIDTH_ACC   // Sum width
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             initial_acc_en,  // Sample starts a new sum
  input  logic        [DATA_WIDTH_ACC-1:0] initial_acc,     // Start value for new sum
  input  logic                             data_in_valid,   // Sample pair present
  input  logic signed [DATA_WIDTH-1:0]     data_in_v1,      // Spectrum A sample
  input  logic signed [DATA_WIDTH-1:0]     data_in_v2,      // Spectrum B sample
  output logic                             data_out_valid,  // Three cycles after input
  output logic        [DATA_WIDTH_ACC-1:0] data_out         // Running sum
);

  logic                             en_1;    // Stage 1 holds a sample
  logic                             en_2;    // Stage 2 holds a sample
  logic                             init_1;  // Start flag in stage 1
  logic                             init_2;  // Start flag in stage 2
  logic signed [DATA_WIDTH:0]       diff;    // One extra bit for full swing
  logic        [DATA_WIDTH_MUL-1:0] mult;    // Square of diff
  logic        [DATA_WIDTH_ACC-1:0] acc_1;   // Start value in stage 1
  logic        [DATA_WIDTH_ACC-1:0] acc_2;   // Start value in stage 2
  logic        [DATA_WIDTH_ACC-1:0] base;    // Addend for stage 3

  assign base = init_2 ? acc_2 : data_out;  // New sum or keep adding

  // Valid and start flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_1   <= 1'b0;
      en_2   <= 1'b0;
      init_1 <= 1'b0;
      init_2 <= 1'b0;
    end else begin
      en_1   <= data_in_valid;
      en_2   <= en_1;
      init_1 <= data_in_valid && initial_acc_en;  // Flag rides with its sample
      init_2 <= en_1 && init_1;
    end
  end

  // Datapath of stages 1 and 2
  always_ff @(posedge clk) begin
    if (data_in_valid) begin
      diff  <= (DATA_WIDTH + 1)'(data_in_v1) - (DATA_WIDTH + 1)'(data_in_v2);  // Never wraps
      acc_1 <= initial_acc;
    end
    if (en_1) begin
      mult  <= DATA_WIDTH_MUL'(diff) * DATA_WIDTH_MUL'(diff);  // Sign-extended square
      acc_2 <= acc_1;
    end
  end

  // Stage 3 accumulator
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
      data_out       <= '0;
    end else begin
      data_out_valid <= en_2;
      if (en_2) begin
        data_out <= base + DATA_WIDTH_ACC'(mult);  // Square is never negative
      end
    end
  end

  // Pipeline depth is fixed at three whatever the input gaps
  assert property (@(posedge clk) disable iff (!rst_n)
    data_out_valid == $past(data_in_valid, 3))
    else $error("sq_df_acc: output valid out of step with input");

endmodule

//--- mse_lane/mse_lane.sv
`timescale 1ns/1ps

module mse_lane #(
  parameter int DATA_WIDTH     = hsi_mse_pkg::HM_DATA_WIDTH,
  parameter int DATA_WIDTH_MUL = hsi_mse_pkg::HM_DATA_WIDTH_MUL,
  parameter int DATA_WIDTH_ACC = hsi_mse_pkg::HM_DATA_WIDTH_ACC,
  parameter int ADDR_WIDTH     = hsi_mse_pkg::HM_ADDR_WIDTH,
  parameter int NUM_BANDS      = 16  // Samples per spectrum
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      job_req,      // Four-phase request
  output logic                      job_ack,      // High while result is final
  input  logic [ADDR_WIDTH-1:0]     base_a,       // First sample of spectrum A
  input  logic [ADDR_WIDTH-1:0]     base_b,       // First sample of spectrum B
  input  logic [DATA_WIDTH_ACC-1:0] acc_init,     // Partial sum from host
  input  logic                      acc_init_en,  // Use acc_init instead of result
  output logic [DATA_WIDTH_ACC-1:0] result,       // Sum of squared differences
  output logic                      rd_req,       // Held until granted
  output logic [ADDR_WIDTH-1:0]     rd_addr,
  input  logic                      rd_gnt,
  input  logic                      rd_valid,     // One cycle after grant
  input  logic [DATA_WIDTH-1:0]     rd_data
);

  localparam int RD_CNT_W  = $clog2(2 * NUM_BANDS);
  localparam int OUT_CNT_W = $clog2(NUM_BANDS + 1);
  localparam logic [RD_CNT_W-1:0]  LAST_RD  = RD_CNT_W'(2 * NUM_BANDS - 1);
  localparam logic [OUT_CNT_W-1:0] LAST_OUT = OUT_CNT_W'(NUM_BANDS - 1);

  hsi_mse_pkg::lane_state_e     state;
  logic [RD_CNT_W-1:0]          rd_cnt;      // Bit 0 picks A or B
  logic [OUT_CNT_W-1:0]         out_cnt;     // Sums seen at pipeline output
  logic                         rtn_second;  // Next return completes a pair
  logic                         first_band;  // Next pair opens the sum
  logic signed [DATA_WIDTH-1:0] sample_a;    // Held A sample
  logic                         pair_valid;
  logic [DATA_WIDTH_ACC-1:0]    start_acc;
  logic                         sq_valid;
  logic [DATA_WIDTH_ACC-1:0]    sq_sum;

  assign rd_req     = (state == hsi_mse_pkg::FETCH);
  assign rd_addr    = (rd_cnt[0] ? base_b : base_a) + ADDR_WIDTH'(rd_cnt >> 1);  // Base plus band
  assign job_ack    = (state == hsi_mse_pkg::DONE);
  assign pair_valid = rd_valid && rtn_second;            // B sample arriving
  assign start_acc  = acc_init_en ? acc_init : result;   // Chunked sums continue

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= hsi_mse_pkg::IDLE;
      rd_cnt     <= '0;
      out_cnt    <= '0;
      rtn_second <= 1'b0;
      first_band <= 1'b0;
      result     <= '0;
    end else begin
      if (rd_valid) begin
        rtn_second <= !rtn_second;  // Returns alternate A then B
      end
      if (pair_valid) begin
        first_band <= 1'b0;
      end
      if (sq_valid) begin
        out_cnt <= out_cnt + 1'b1;  // Counts during FETCH too
      end
      case (state)
        hsi_mse_pkg::IDLE: begin
          if (job_req) begin
            state      <= hsi_mse_pkg::FETCH;
            rd_cnt     <= '0;
            out_cnt    <= '0;
            rtn_second <= 1'b0;
            first_band <= 1'b1;
          end
        end
        hsi_mse_pkg::FETCH: begin
          if (rd_gnt) begin
            rd_cnt <= rd_cnt + 1'b1;  // Address moves only on grant
            if (rd_cnt == LAST_RD) begin
              state <= hsi_mse_pkg::DRAIN;
            end
          end
        end
        hsi_mse_pkg::DRAIN: begin
          if (sq_valid && out_cnt == LAST_OUT) begin
            result <= sq_sum;  // Last band summed
            state  <= hsi_mse_pkg::DONE;
          end
        end
        hsi_mse_pkg::DONE: begin
          if (!job_req) begin
            state <= hsi_mse_pkg::IDLE;  // Ack drops with state
          end
        end
        default: state <= hsi_mse_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid && !rtn_second) begin
      sample_a <= rd_data;  // Wait here for its B partner
    end
  end

  sq_df_acc #(
    .DATA_WIDTH     (DATA_WIDTH),
    .DATA_WIDTH_MUL (DATA_WIDTH_MUL),
    .DATA_WIDTH_ACC (DATA_WIDTH_ACC)
  ) u_sq_df_acc (
    .clk            (clk),
    .rst_n          (rst_n),
    .initial_acc_en (first_band),
    .initial_acc    (start_acc),
    .data_in_valid  (pair_valid),
    .data_in_v1     (sample_a),
    .data_in_v2     (rd_data),
    .data_out_valid (sq_valid),
    .data_out       (sq_sum)
  );

  // Four-phase rule seen from the host side
  assert property (@(posedge clk) disable iff (!rst_n) $rose(job_ack) |-> job_req)
    else $error("mse_lane: job_ack rose without job_req");

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int DATA_WIDTH = hsi_mse_pkg::HM_DATA_WIDTH,
  parameter int ADDR_WIDTH = hsi_mse_pkg::HM_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rd_req_0,
  input  logic [ADDR_WIDTH-1:0] rd_addr_0,
  output logic                  rd_gnt_0,
  output logic                  rd_valid_0,
  output logic [DATA_WIDTH-1:0] rd_data_0,
  input  logic                  rd_req_1,
  input  logic [ADDR_WIDTH-1:0] rd_addr_1,
  output logic                  rd_gnt_1,
  output logic                  rd_valid_1,
  output logic [DATA_WIDTH-1:0] rd_data_1,
  output logic                  mem_re,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  input  logic [DATA_WIDTH-1:0] mem_rdata  // One cycle after mem_re
);

  logic prio_1;   // Lane 1 wins a tie
  logic owner_1;  // Lane 1 owns data in flight
  logic rtn_q;    // Data in flight

  assign rd_gnt_0 = rd_req_0 && (!rd_req_1 || !prio_1);
  assign rd_gnt_1 = rd_req_1 && (!rd_req_0 || prio_1);
  assign mem_re   = rd_gnt_0 || rd_gnt_1;
  assign mem_addr = rd_gnt_1 ? rd_addr_1 : rd_addr_0;

  assign rd_valid_0 = rtn_q && !owner_1;
  assign rd_valid_1 = rtn_q && owner_1;
  assign rd_data_0  = rd_valid_0 ? mem_rdata : '0;  // Only the owner sees data
  assign rd_data_1  = rd_valid_1 ? mem_rdata : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_1  <= 1'b0;
      owner_1 <= 1'b0;
      rtn_q   <= 1'b0;
    end else begin
      rtn_q   <= mem_re;
      owner_1 <= rd_gnt_1;
      if (mem_re) begin
        prio_1 <= rd_gnt_0;  // Favour the lane not just served
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(rd_gnt_0 && rd_gnt_1))
    else $error("mem_arbiter: both lanes granted");

  // A lane that lost arbitration wins the next cycle if it still asks
  assert property (@(posedge clk) disable iff (!rst_n)
    rd_req_0 && !rd_gnt_0 |=> !rd_req_0 || rd_gnt_0)
    else $error("mem_arbiter: lane 0 passed over twice");

  assert property (@(posedge clk) disable iff (!rst_n)
    rd_req_1 && !rd_gnt_1 |=> !rd_req_1 || rd_gnt_1)
    else $error("mem_arbiter: lane 1 passed over twice");

endmodule

//--- verilog/spectrum_mem.sv
`timescale 1ns/1ps

module spectrum_mem #(
  parameter int DATA_WIDTH = hsi_mse_pkg::HM_DATA_WIDTH,
  parameter int ADDR_WIDTH = hsi_mse_pkg::HM_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  wr_en,      // Host write strobe
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  mem_re,     // Read from arbiter
  input  logic [ADDR_WIDTH-1:0] mem_addr,
  output logic [DATA_WIDTH-1:0] mem_rdata   // Valid the cycle after mem_re
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];  // Spectra stored band by band

  // Single clock RAM with one write and one read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read returns old data on a same-address write
  always_ff @(posedge clk) begin
    if (mem_re) begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

//--- verilog/hsi_mse_top.sv
`timescale 1ns/1ps

module hsi_mse_top #(
  parameter int DATA_WIDTH     = hsi_mse_pkg::HM_DATA_WIDTH,
  parameter int DATA_WIDTH_MUL = hsi_mse_pkg::HM_DATA_WIDTH_MUL,
  parameter int DATA_WIDTH_ACC = hsi_mse_pkg::HM_DATA_WIDTH_ACC,
  parameter int ADDR_WIDTH     = hsi_mse_pkg::HM_ADDR_WIDTH,
  parameter int NUM_BANDS      = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_en,          // Spectrum preload
  input  logic [ADDR_WIDTH-1:0]     wr_addr,
  input  logic [DATA_WIDTH-1:0]     wr_data,
  input  logic                      job_req_0,      // Lane 0 host port
  output logic                      job_ack_0,
  input  logic [ADDR_WIDTH-1:0]     base_a_0,
  input  logic [ADDR_WIDTH-1:0]     base_b_0,
  input  logic [DATA_WIDTH_ACC-1:0] acc_init_0,
  input  logic                      acc_init_en_0,
  output logic [DATA_WIDTH_ACC-1:0] result_0,
  input  logic                      job_req_1,      // Lane 1 host port
  output logic                      job_ack_1,
  input  logic [ADDR_WIDTH-1:0]     base_a_1,
  input  logic [ADDR_WIDTH-1:0]     base_b_1,
  input  logic [DATA_WIDTH_ACC-1:0] acc_init_1,
  input  logic                      acc_init_en_1,
  output logic [DATA_WIDTH_ACC-1:0] result_1
);

  logic                  rd_req_0;    // Lane 0 read bus
  logic [ADDR_WIDTH-1:0] rd_addr_0;
  logic                  rd_gnt_0;
  logic                  rd_valid_0;
  logic [DATA_WIDTH-1:0] rd_data_0;
  logic                  rd_req_1;    // Lane 1 read bus
  logic [ADDR_WIDTH-1:0] rd_addr_1;
  logic                  rd_gnt_1;
  logic                  rd_valid_1;
  logic [DATA_WIDTH-1:0] rd_data_1;
  logic                  mem_re;      // Shared RAM read port
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0] mem_rdata;

  spectrum_mem #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_spectrum_mem (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .mem_re    (mem_re),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata)
  );

  mem_arbiter #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mem_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req_0   (rd_req_0),
    .rd_addr_0  (rd_addr_0),
    .rd_gnt_0   (rd_gnt_0),
    .rd_valid_0 (rd_valid_0),
    .rd_data_0  (rd_data_0),
    .rd_req_1   (rd_req_1),
    .rd_addr_1  (rd_addr_1),
    .rd_gnt_1   (rd_gnt_1),
    .rd_valid_1 (rd_valid_1),
    .rd_data_1  (rd_data_1),
    .mem_re     (mem_re),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata)
  );

  mse_lane #(
    .DATA_WIDTH     (DATA_WIDTH),
    .DATA_WIDTH_MUL (DATA_WIDTH_MUL),
    .DATA_WIDTH_ACC (DATA_WIDTH_ACC),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .NUM_BANDS      (NUM_BANDS)
  ) u_lane_0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .job_req     (job_req_0),
    .job_ack     (job_ack_0),
    .base_a      (base_a_0),
    .base_b      (base_b_0),
    .acc_init    (acc_init_0),
    .acc_init_en (acc_init_en_0),
    .result      (result_0),
    .rd_req      (rd_req_0),
    .rd_addr     (rd_addr_0),
    .rd_gnt      (rd_gnt_0),
    .rd_valid    (rd_valid_0),
    .rd_data     (rd_data_0)
  );

  mse_lane #(
    .DATA_WIDTH     (DATA_WIDTH),
    .DATA_WIDTH_MUL (DATA_WIDTH_MUL),
    .DATA_WIDTH_ACC (DATA_WIDTH_ACC),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .NUM_BANDS      (NUM_BANDS)
  ) u_lane_1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .job_req     (job_req_1),
    .job_ack     (job_ack_1),
    .base_a      (base_a_1),
    .base_b      (base_b_1),
    .acc_init    (acc_init_1),
    .acc_init_en (acc_init_en_1),
    .result      (result_1),
    .rd_req      (rd_req_1),
    .rd_addr     (rd_addr_1),
    .rd_gnt      (rd_gnt_1),
    .rd_valid    (rd_valid_1),
    .rd_data     (rd_data_1)
  );

endmodule

//--- verification/hsi_mse_tb.sv
`timescale 1ns/1ps

module hsi_mse_tb;

  localparam int DATA_W    = hsi_mse_pkg::HM_DATA_WIDTH;
  localparam int MUL_W     = hsi_mse_pkg::HM_DATA_WIDTH_MUL;
  localparam int ACC_W     = hsi_mse_pkg::HM_DATA_WIDTH_ACC;
  localparam int ADDR_W    = hsi_mse_pkg::HM_ADDR_WIDTH;
  localparam int NUM_BANDS = 16;
  localparam int MEM_WORDS = 256;  // Preloaded part of the RAM
  localparam int JOBS      = 15;   // Jobs over all tests
  localparam int RST_CYC   = 10;
  localparam int WDOG_CYC  = RST_CYC + MEM_WORDS + 2 + JOBS * (4 * NUM_BANDS + 20);

  logic                        clk;
  logic                        rst_n;
  logic                        wr_en;
  logic [ADDR_W-1:0]           wr_addr;
  logic [DATA_W-1:0]           wr_data;
  logic [1:0]                  job_req;
  logic [1:0]                  job_ack;
  logic [1:0][ADDR_W-1:0]      base_a;
  logic [1:0][ADDR_W-1:0]      base_b;
  logic [1:0][ACC_W-1:0]       acc_init;
  logic [1:0]                  acc_init_en;
  logic [1:0][ACC_W-1:0]       job_res;
  logic [1:0][ACC_W-1:0]       exp_res;                 // Last expected sum per lane
  logic [DATA_W-1:0]           mem_copy [2 ** ADDR_W];  // Host image of the RAM
  logic [15:0]                 lfsr_state;
  int                          jobs_checked;

  hsi_mse_top #(
    .DATA_WIDTH     (DATA_W),
    .DATA_WIDTH_MUL (MUL_W),
    .DATA_WIDTH_ACC (ACC_W),
    .ADDR_WIDTH     (ADDR_W),
    .NUM_BANDS      (NUM_BANDS)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .job_req_0     (job_req[0]),
    .job_ack_0     (job_ack[0]),
    .base_a_0      (base_a[0]),
    .base_b_0      (base_b[0]),
    .acc_init_0    (acc_init[0]),
    .acc_init_en_0 (acc_init_en[0]),
    .result_0      (job_res[0]),
    .job_req_1     (job_req[1]),
    .job_ack_1     (job_ack[1]),
    .base_a_1      (base_a[1]),
    .base_b_1      (base_b[1]),
    .acc_init_1    (acc_init[1]),
    .acc_init_en_1 (acc_init_en[1]),
    .result_1      (job_res[1])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Expected sum of squared band differences
  function automatic logic [ACC_W-1:0] ref_sum(input int a, input int b,
                                                input logic [ACC_W-1:0] start);
    longint d;
    logic [ACC_W-1:0] s;
    s = start;
    for (int i = 0; i < NUM_BANDS; i++) begin
      d = longint'($signed(mem_copy[ADDR_W'(a + i)]))
        - longint'($signed(mem_copy[ADDR_W'(b + i)]));
      s = s + ACC_W'(d * d);
    end
    return s;
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic preload_memory();
    logic [DATA_W-1:0] v;
    for (int i = 0; i < MEM_WORDS; i++) begin
      v = DATA_W'(rand_bits(DATA_W));
      if (i >= 224 && i < 240) v = 16'h7FFF;  // Most positive block
      if (i >= 240) v = 16'h8000;              // Most negative block
      @(posedge clk);
      #2;
      wr_en   = 1'b1;
      wr_addr = ADDR_W'(i);
      wr_data = v;
      mem_copy[ADDR_W'(i)] = v;
    end
    @(posedge clk);
    #2;
    wr_en = 1'b0;
  endtask

  // One four-phase job with req held for hold extra cycles after ack
  task automatic run_job(input int ln, input int a, input int b,
                         input logic [ACC_W-1:0] init, input logic init_en, input int hold);
    logic [ACC_W-1:0] start;
    start = init_en ? init : exp_res[ln];  // Chunked sum continues
    exp_res[ln] = ref_sum(a, b, start);
    @(posedge clk);
    #2;
    base_a[ln]      = ADDR_W'(a);
    base_b[ln]      = ADDR_W'(b);
    acc_init[ln]    = init;
    acc_init_en[ln] = init_en;
    job_req[ln]     = 1'b1;
    do @(posedge clk); while (!job_ack[ln]);
    repeat (hold) @(posedge clk);  // Host stalls completion
    #2;
    job_req[ln] = 1'b0;
    do @(posedge clk); while (job_ack[ln]);
  endtask

  // Compare and handshake checks per lane
  for (genvar g = 0; g < 2; g++) begin : g_check
    logic             ack_q;
    logic [ACC_W-1:0] held;
    always @(posedge clk) begin
      if (!rst_n) begin
        ack_q = 1'b0;
      end else begin
        if (job_ack[g] && !ack_q) begin
          assert (job_req[g]) else
            stop_with_failure($sformatf("Lane %0d raised ack without a request", g));
          assert (job_res[g] == exp_res[g]) else
            stop_with_failure($sformatf("Fail at %0t: lane %0d result %0h, expected %0h",
                                        $time, g, job_res[g], exp_res[g]));
          held = job_res[g];
          jobs_checked++;
        end else if (job_ack[g]) begin
          assert (job_res[g] == held) else
            stop_with_failure($sformatf("Fail at %0t: lane %0d result moved while ack high",
                                        $time, g));
        end else if (ack_q) begin
          assert (!job_req[g]) else
            stop_with_failure($sformatf("Lane %0d dropped ack while req still high", g));
        end
        ack_q = job_ack[g];
      end
    end
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    stop_with_failure("Watchdog expired before all jobs completed");
  end

  initial begin
    int               a0;
    int               b0;
    int               a1;
    int               b1;
    logic [ACC_W-1:0] init0;
    logic [ACC_W-1:0] init1;
    logic             en0;
    logic             en1;
    int               hold0;
    int               hold1;
    rst_n        = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    job_req      = '0;
    base_a       = '0;
    base_b       = '0;
    acc_init     = '0;
    acc_init_en  = '0;
    exp_res      = '0;  // Lane result resets to zero
    lfsr_state   = 16'd20;
    jobs_checked = 0;
    repeat (RST_CYC) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    assert (job_ack == 2'b00) else
      stop_with_failure($sformatf("Fail at %0t: job_ack %b after reset", $time, job_ack));
    preload_memory();
    run_job(0, 0, 16, '0, 1'b1, 0);  // Single job
    fork  // Both lanes contend
      run_job(0, 32, 48, '0, 1'b1, 0);
      run_job(1, 64, 80, '0, 1'b1, 2);
    join
    fork  // Continue and nonzero start
      run_job(0, 96, 112, '0, 1'b0, 1);
      run_job(1, 128, 144, 48'h0000_1234_5678, 1'b1, 0);
    join
    fork  // Full-scale samples
      run_job(1, 224, 240, '0, 1'b1, 0);
      run_job(0, 240, 224, '0, 1'b0, 3);
    join
    repeat (4) begin
      a0    = int'(rand_bits(8) % (MEM_WORDS - NUM_BANDS + 1));
      b0    = int'(rand_bits(8) % (MEM_WORDS - NUM_BANDS + 1));
      a1    = int'(rand_bits(8) % (MEM_WORDS - NUM_BANDS + 1));
      b1    = int'(rand_bits(8) % (MEM_WORDS - NUM_BANDS + 1));
      init0 = ACC_W'(rand_bits(16));
      en0   = rand_bits(1) != 0;
      hold0 = int'(rand_bits(2));
      init1 = ACC_W'(rand_bits(16));
      en1   = rand_bits(1) != 0;
      hold1 = int'(rand_bits(2));
      fork
        run_job(0, a0, b0, init0, en0, hold0);
        run_job(1, a1, b1, init1, en1, hold1);
      join
    end
    repeat (2) @(posedge clk);
    if (jobs_checked == JOBS) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_with_failure($sformatf("Only %0d of %0d jobs were checked", jobs_checked, JOBS));
    end
  end

endmodule

//--- hsi_mse_top.f
common/hsi_mse_pkg.sv
mse_lane/sq_df_acc.sv
mse_lane/mse_lane.sv
verilog/mem_arbiter.sv
verilog/spectrum_mem.sv
verilog/hsi_mse_top.sv
verification/hsi_mse_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = hsi_mse_tb
FILELIST = hsi_mse_top.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
